//--- design/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// image geometry
`define CONV_LINE_WIDTH 16

// 3x3 window
`define CONV_TAPS 9

// pixel lanes packed into one input word
`define CONV_LANES 2
`define CONV_PIX_W 8

// kernel coefficient and index widths
`define CONV_COEF_W 8
`define CONV_KIDX_W 4

// 9-bit zero-extended pixel times 8-bit signed coefficient
`define CONV_PROD_W 17

// nine products plus headroom
`define CONV_ACC_W 20

// output scaling, round then shift right
`define CONV_SHIFT 7

`endif

//--- design/conv_pkg.sv
`include "conv_params.svh"

package conv_pkg;

	// one unsigned lane pixel
	typedef logic [`CONV_PIX_W-1:0] pixel_t;

	// two lanes, high lane in the upper byte
	typedef logic [`CONV_LANES*`CONV_PIX_W-1:0] pix_word_t;

	typedef logic signed [`CONV_COEF_W-1:0] coef_t;

	// kernel index 0..8
	typedef logic [`CONV_KIDX_W-1:0] kidx_t;

	typedef logic signed [`CONV_PROD_W-1:0] prod_t;

	typedef logic signed [`CONV_ACC_W-1:0] acc_t;

	// tap (r, c) sits at index 3r+c, row 0 and column 0 are the oldest
	typedef pix_word_t [`CONV_TAPS-1:0] window_t;

	typedef coef_t [`CONV_TAPS-1:0] kernel_t;

endpackage

//--- design/conv_window_gen.sv
`include "conv_params.svh"

module conv_window_gen #(
	parameter int LINE_WIDTH = `CONV_LINE_WIDTH
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                pixel_valid,
	input  logic                sof,
	input  conv_pkg::pix_word_t pixel_in,
	output logic                win_valid,
	output conv_pkg::window_t   window
);
	import conv_pkg::*;

	localparam int COL_W = $clog2(LINE_WIDTH);
	localparam logic [COL_W-1:0] LAST_COL = COL_W'(LINE_WIDTH - 1);

	logic [COL_W-1:0] col_cnt;
	logic [COL_W-1:0] cur_col;
	logic [COL_W-1:0] next_col;
	logic [1:0]       row_cnt;
	logic [1:0]       cur_row;
	logic [1:0]       next_row;
	logic             line_end;

	// row memories, mem0 holds the previous line, mem1 the one before
	pix_word_t row_mem0 [LINE_WIDTH];
	pix_word_t row_mem1 [LINE_WIDTH];

	// vertical taps of the current column, index 0 is the oldest row
	pix_word_t col_tap [3];

	//////////////////////////////////////////////////////////////////////
	// position of the strobed pixel
	//////////////////////////////////////////////////////////////////////

	// sof makes the current pixel row 0, column 0
	always_comb begin
		if (sof) begin
			cur_col = '0;
			cur_row = '0;
		end else begin
			cur_col = col_cnt;
			cur_row = row_cnt;
		end
	end

	assign line_end = (cur_col == LAST_COL);

	always_comb begin
		if (line_end) begin
			next_col = '0;
			// saturate, only "two rows above exist" matters
			next_row = (cur_row == 2'd2) ? 2'd2 : cur_row + 2'd1;
		end else begin
			next_col = cur_col + 1'b1;
			next_row = cur_row;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			col_cnt   <= '0;
			row_cnt   <= '0;
			win_valid <= 1'b0;
		end else begin
			win_valid <= 1'b0;
			if (pixel_valid) begin
				col_cnt   <= next_col;
				row_cnt   <= next_row;
				win_valid <= (cur_row == 2'd2) && (cur_col >= COL_W'(2));
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// line buffer cascade
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		col_tap[0] = row_mem1[cur_col];
		col_tap[1] = row_mem0[cur_col];
		col_tap[2] = pixel_in;
	end

	// read old word, write newer one, each memory feeds the next
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			row_mem0[cur_col] <= pixel_in;
			row_mem1[cur_col] <= row_mem0[cur_col];
		end
	end

	// 3x3 window, columns shift toward index 0
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			for (int r = 0; r < 3; r++) begin
				window[3*r]   <= window[3*r+1];
				window[3*r+1] <= window[3*r+2];
				window[3*r+2] <= col_tap[r];
			end
		end
	end

endmodule

//--- design/conv_kernel_regs.sv
`include "conv_params.svh"

module conv_kernel_regs (
	input  logic              clk,
	input  logic              rst,
	input  logic              knl_wr,
	input  conv_pkg::kidx_t   knl_addr,
	input  conv_pkg::coef_t   knl_data,
	output conv_pkg::kernel_t kernel
);
	import conv_pkg::*;

	// one write enable per coefficient
	logic [`CONV_TAPS-1:0] wr_hit;

	// addresses above the last tap match no entry and are dropped
	always_comb begin
		for (int i = 0; i < `CONV_TAPS; i++) begin
			wr_hit[i] = knl_wr && (knl_addr == kidx_t'(i));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// coefficient registers
	//////////////////////////////////////////////////////////////////////

	genvar gi;
	generate
		for (gi = 0; gi < `CONV_TAPS; gi++) begin : g_coef
			always_ff @(posedge clk) begin
				if (rst) begin
					kernel[gi] <= '0;
				end else if (wr_hit[gi]) begin
					kernel[gi] <= knl_data;
				end
			end
		end
	endgenerate

endmodule

//--- design/conv_mac_tree.sv
`include "conv_params.svh"

module conv_mac_tree (
	input  logic                clk,
	input  logic                rst,
	input  logic                win_valid,
	input  conv_pkg::window_t   window,
	input  conv_pkg::kernel_t   kernel,
	output logic                out_valid,
	output conv_pkg::pix_word_t pixel_out
);
	import conv_pkg::*;

	localparam int NL = `CONV_LANES;

	// half an output step, added before the shift
	localparam acc_t ROUND = acc_t'(2 ** (`CONV_SHIFT - 1));

	prod_t prod [NL][`CONV_TAPS];
	acc_t  lane_sum_d [NL];
	acc_t  lane_sum [NL];
	acc_t  rounded [NL];
	logic  prod_valid;
	logic  sum_valid;

	// lane 0 is the low byte
	function automatic pixel_t lane_of(input pix_word_t w, input int l);
		return w[l*`CONV_PIX_W +: `CONV_PIX_W];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stage 1, products
	//////////////////////////////////////////////////////////////////////

	// pixel is unsigned, zero-extend before the signed multiply
	always_ff @(posedge clk) begin
		if (win_valid) begin
			for (int l = 0; l < NL; l++) begin
				for (int t = 0; t < `CONV_TAPS; t++) begin
					prod[l][t] <= $signed({1'b0, lane_of(window[t], l)})
						* $signed(kernel[t]);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stage 2, lane sums
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int l = 0; l < NL; l++) begin
			lane_sum_d[l] = '0;
			for (int t = 0; t < `CONV_TAPS; t++) begin
				lane_sum_d[l] = lane_sum_d[l] + acc_t'(prod[l][t]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid) begin
			lane_sum <= lane_sum_d;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stage 3, round, shift, pack
	//////////////////////////////////////////////////////////////////////

	// arithmetic shift keeps the sign of negative sums
	always_comb begin
		for (int l = 0; l < NL; l++) begin
			rounded[l] = (lane_sum[l] + ROUND) >>> `CONV_SHIFT;
		end
	end

	// low 8 bits only, larger results wrap
	always_ff @(posedge clk) begin
		if (sum_valid) begin
			for (int l = 0; l < NL; l++) begin
				pixel_out[l*`CONV_PIX_W +: `CONV_PIX_W] <= pixel_t'(rounded[l]);
			end
		end
	end

	// valid bit alongside each stage
	always_ff @(posedge clk) begin
		if (rst) begin
			prod_valid <= 1'b0;
			sum_valid  <= 1'b0;
			out_valid  <= 1'b0;
		end else begin
			prod_valid <= win_valid;
			sum_valid  <= prod_valid;
			out_valid  <= sum_valid;
		end
	end

endmodule

//--- design/conv_top.sv
module conv_top (
	input  logic                clk,
	input  logic                rst,

	// pixel stream, one pixel per strobe
	input  logic                pixel_valid,
	input  logic                sof,
	input  conv_pkg::pix_word_t pixel_in,

	// kernel write port
	input  logic                knl_wr,
	input  conv_pkg::kidx_t     knl_addr,
	input  conv_pkg::coef_t     knl_data,

	// filtered stream
	output logic                out_valid,
	output conv_pkg::pix_word_t pixel_out
);
	import conv_pkg::*;

	logic    win_valid;
	window_t window;
	kernel_t kernel;

	//////////////////////////////////////////////////////////////////////
	// window generation
	//////////////////////////////////////////////////////////////////////

	conv_window_gen u_window_gen (
		.clk         (clk),
		.rst         (rst),
		.pixel_valid (pixel_valid),
		.sof         (sof),
		.pixel_in    (pixel_in),
		.win_valid   (win_valid),
		.window      (window)
	);

	//////////////////////////////////////////////////////////////////////
	// kernel
	//////////////////////////////////////////////////////////////////////

	conv_kernel_regs u_kernel_regs (
		.clk      (clk),
		.rst      (rst),
		.knl_wr   (knl_wr),
		.knl_addr (knl_addr),
		.knl_data (knl_data),
		.kernel   (kernel)
	);

	//////////////////////////////////////////////////////////////////////
	// multiply-accumulate, three stages
	//////////////////////////////////////////////////////////////////////

	conv_mac_tree u_mac_tree (
		.clk       (clk),
		.rst       (rst),
		.win_valid (win_valid),
		.window    (window),
		.kernel    (kernel),
		.out_valid (out_valid),
		.pixel_out (pixel_out)
	);

endmodule

//--- testbench/conv_properties.sv
module conv_properties (
	input logic clk,
	input logic rst,
	input logic pixel_valid,
	input logic knl_wr,
	input logic win_valid,
	input logic out_valid
);

	// cycles since reset, the latency check needs four of history
	logic [2:0] hist;

	always_ff @(posedge clk) begin
		if (rst) begin
			hist <= '0;
		end else if (hist != 3'd7) begin
			hist <= hist + 3'd1;
		end
	end

	// complete window strobed 4 cycles back, seen by the window generator
	a_latency: assert property (@(posedge clk) disable iff (rst || hist < 3'd4)
		out_valid == ($past(pixel_valid, 4) && $past(win_valid, 3)))
		else $error("out_valid does not follow a complete window by four cycles");

	a_reset_quiet: assert property (@(posedge clk) $past(rst) |-> !out_valid)
		else $error("out_valid is high during or right after reset");

	a_kernel_idle: assert property (@(posedge clk) disable iff (rst)
		knl_wr |-> !(pixel_valid || win_valid))
		else $error("kernel written while pixels are streaming");

endmodule

bind conv_top conv_properties u_properties (
	.clk         (clk),
	.rst         (rst),
	.pixel_valid (pixel_valid),
	.knl_wr      (knl_wr),
	.win_valid   (win_valid),
	.out_valid   (out_valid)
);

//--- testbench/tb_conv.sv
`include "conv_params.svh"

module tb_conv;
	import conv_pkg::*;

	localparam int W = `CONV_LINE_WIDTH;
	localparam int PW = `CONV_PIX_W;
	// every frame of every test plus the stray pixels before the restart frame
	localparam int TOTAL_PIXELS = W * 36 + 7;
	localparam logic [31:0] SEED = 32'h8d965e66;

	logic clk;
	logic rst;
	logic pixel_valid;
	logic sof;
	pix_word_t pixel_in;
	logic knl_wr;
	kidx_t knl_addr;
	coef_t knl_data;
	logic out_valid;
	pix_word_t pixel_out;

	pix_word_t img [$];
	pix_word_t exp_q [$];
	pix_word_t got_q [$];
	kernel_t model_knl;
	string cur_test;
	int errors;
	int checks;
	int n_tests;
	int err_at_start;

	conv_top dut (
		.clk         (clk),
		.rst         (rst),
		.pixel_valid (pixel_valid),
		.sof         (sof),
		.pixel_in    (pixel_in),
		.knl_wr      (knl_wr),
		.knl_addr    (knl_addr),
		.knl_data    (knl_data),
		.out_valid   (out_valid),
		.pixel_out   (pixel_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#(TOTAL_PIXELS * 4 * 3 + 1000);
		$display("watchdog: the run took longer than the tests allow, stopping");
		$display("TEST FAIL");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks and output monitor
	//////////////////////////////////////////////////////////////////////

	// each lane is checked on its own
	task automatic compare_word(input pix_word_t expected, input pix_word_t actual);
		pixel_t e;
		pixel_t a;
		for (int l = 0; l < 2; l++) begin
			e = expected[l*PW +: PW];
			a = actual[l*PW +: PW];
			checks++;
			if (e !== a) begin
				errors++;
				$display("error %s lane %0d: expected %h, actual %h", cur_test, l, e, a);
			end
		end
	endtask

	task automatic compare_count(input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("error %s count: expected %0d, actual %0d", cur_test, expected, actual);
		end
	endtask

	always @(negedge clk) begin
		if (out_valid) begin
			got_q.push_back(pixel_out);
			if (exp_q.size() == 0) begin
				errors++;
				$display("%s: the DUT produced an output that was not expected", cur_test);
			end else begin
				compare_word(exp_q.pop_front(), pixel_out);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus and reference model
	//////////////////////////////////////////////////////////////////////

	task automatic write_coef(input kidx_t addr, input coef_t data);
		@(negedge clk);
		knl_wr = 1'b1;
		knl_addr = addr;
		knl_data = data;
		@(negedge clk);
		knl_wr = 1'b0;
	endtask

	task automatic load_kernel(input kernel_t k);
		for (int i = 0; i < `CONV_TAPS; i++) begin
			write_coef(kidx_t'(i), k[i]);
		end
		model_knl = k;
	endtask

	function automatic kernel_t random_kernel(input int lo, input int hi);
		kernel_t k;
		for (int i = 0; i < `CONV_TAPS; i++) begin
			k[i] = coef_t'(lo + int'($urandom_range(hi - lo)));
		end
		return k;
	endfunction

	task automatic make_image(input int n_pix, input pix_word_t or_mask);
		img.delete();
		for (int p = 0; p < n_pix; p++) begin
			img.push_back(pix_word_t'($urandom) | or_mask);
		end
	endtask

	function automatic int lane_px(input int p, input int l);
		pix_word_t w;
		w = img[p];
		return int'(w[l*PW +: PW]);
	endfunction

	// tap (r, c) is pixel (row-2+r, col-2+c) weighted by kernel index 3r+c
	task automatic model_expect(input int n_pix);
		int s;
		pix_word_t w;
		for (int p = 0; p < n_pix; p++) begin
			if (p / W >= 2 && p % W >= 2) begin
				for (int l = 0; l < 2; l++) begin
					s = 0;
					for (int r = 0; r < 3; r++) begin
						for (int c = 0; c < 3; c++) begin
							s += lane_px(p - (2 - r) * W - (2 - c), l)
								* int'($signed(model_knl[3*r+c]));
						end
					end
					s = (s + (1 << (`CONV_SHIFT - 1))) >>> `CONV_SHIFT;
					w[l*PW +: PW] = s[7:0];
				end
				exp_q.push_back(w);
			end
		end
	endtask

	// sof on the first pixel and random idle cycles of up to max_gap between strobes
	task automatic stream_pixels(input int n_pix, input int max_gap);
		int gap;
		for (int p = 0; p < n_pix; p++) begin
			@(negedge clk);
			pixel_valid = 1'b1;
			sof = (p == 0);
			pixel_in = img[p];
			gap = (max_gap > 0) ? int'($urandom_range(max_gap)) : 0;
			repeat (gap) begin
				@(negedge clk);
				pixel_valid = 1'b0;
				sof = 1'b0;
				pixel_in = pix_word_t'($urandom);
			end
		end
		@(negedge clk);
		pixel_valid = 1'b0;
		sof = 1'b0;
	endtask

	task automatic wait_drain;
		int idle;
		idle = 0;
		while (exp_q.size() != 0 && idle < 16) begin
			@(negedge clk);
			idle++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("%s: %0d expected outputs never appeared", cur_test, exp_q.size());
			exp_q.delete();
		end
		// room for any stray output
		repeat (8) @(negedge clk);
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		err_at_start = errors;
		got_q.delete();
	endtask

	task automatic end_test;
		n_tests++;
		$display("test %s finished with %0d errors", cur_test, errors - err_at_start);
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	// centre coefficient -2^7 makes each lane the negated centre pixel
	task automatic test_identity;
		kernel_t k;
		pix_word_t c;
		begin_test("identity");
		k = '0;
		k[4] = coef_t'(-128);
		load_kernel(k);
		write_coef(kidx_t'(12), coef_t'(8'sh7f));
		make_image(W * 5, '0);
		for (int p = 0; p < W * 5; p++) begin
			if (p / W >= 2 && p % W >= 2) begin
				c = img[p - W - 1];
				exp_q.push_back({8'd0 - c[15:8], 8'd0 - c[7:0]});
			end
		end
		stream_pixels(W * 5, 0);
		wait_drain();
		compare_count(3 * (W - 2), got_q.size());
		end_test();
	endtask

	task automatic test_random(input string name, input int lo, input int hi,
		input pix_word_t or_mask);
		begin_test(name);
		load_kernel(random_kernel(lo, hi));
		make_image(W * 6, or_mask);
		model_expect(W * 6);
		stream_pixels(W * 6, 0);
		wait_drain();
		compare_count(4 * (W - 2), got_q.size());
		end_test();
	endtask

	// stray pixels leave the counters mid-line before two frames with sof
	task automatic test_frame_restart;
		begin_test("restart");
		load_kernel(random_kernel(-64, 63));
		make_image(7, '0);
		stream_pixels(7, 0);
		make_image(W * 4, '0);
		model_expect(W * 4);
		stream_pixels(W * 4, 0);
		wait_drain();
		compare_count(2 * (W - 2), got_q.size());
		got_q.delete();
		make_image(W * 5, '0);
		model_expect(W * 5);
		stream_pixels(W * 5, 0);
		wait_drain();
		compare_count(3 * (W - 2), got_q.size());
		end_test();
	endtask

	task automatic test_gapped;
		pix_word_t ref_q [$];
		begin_test("gapped");
		load_kernel(random_kernel(-128, 127));
		make_image(W * 5, '0);
		model_expect(W * 5);
		stream_pixels(W * 5, 0);
		wait_drain();
		ref_q = got_q;
		got_q.delete();
		model_expect(W * 5);
		stream_pixels(W * 5, 2);
		wait_drain();
		compare_count(ref_q.size(), got_q.size());
		for (int i = 0; i < ref_q.size() && i < got_q.size(); i++) begin
			compare_word(ref_q[i], got_q[i]);
		end
		end_test();
	endtask

	initial begin
		int unused_rnd;
		unused_rnd = $urandom(SEED);
		errors = 0;
		checks = 0;
		n_tests = 0;
		rst = 1'b1;
		pixel_valid = 1'b0;
		sof = 1'b0;
		pixel_in = '0;
		knl_wr = 1'b0;
		knl_addr = '0;
		knl_data = '0;
		cur_test = "reset";
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_identity();
		test_random("random", -128, 127, '0);
		test_random("negative", -128, -1, 16'h8080);
		test_frame_restart();
		test_gapped();
		$display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+design
design/conv_pkg.sv
design/conv_window_gen.sv
design/conv_kernel_regs.sv
design/conv_mac_tree.sv
design/conv_top.sv
testbench/conv_properties.sv
testbench/tb_conv.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_conv -o tb_conv

out=$(./obj_dir/tb_conv 2>&1) || true
echo "$out"

# the status of this search is the status of the script
echo "$out" | grep -qx "TEST PASS"
